// File: list.f
+incdir+include
rtl/ex_pkg.sv
rtl/ex_decode.sv
rtl/ex_execute.sv
rtl/ex_result.sv
rtl/ex_unit.sv
test/tb_ex_unit.sv

// File: rtl/ex_decode.sv
module ex_decode import ex_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  logic      op_valid_i,
	input  alu_op_e   aluop_i,
	input  word_t     reg1_i,
	input  word_t     reg2_i,
	input  reg_addr_t wd_i,
	input  logic      wreg_i,
	output logic      dec_valid_o,
	output alu_op_e   dec_op_o,
	output alu_sel_e  dec_sel_o,
	output logic      dec_signed_o,
	output logic      dec_ov_check_o,
	output hilo_act_e dec_hilo_o,
	output word_t     dec_reg1_o,
	output word_t     dec_reg2_o,
	output reg_addr_t dec_wd_o,
	output logic      dec_wreg_o
);

	alu_sel_e  sel_d;
	hilo_act_e hilo_d;
	logic      signed_d;
	logic      ov_check_d;
	logic      keep_wreg_d;

	// classify the incoming code into a class and its side flags.
	// anything not listed, nop included, has no class and writes nothing.
	always_comb
	begin
		sel_d       = SEL_NONE;
		hilo_d      = HILO_NONE;
		signed_d    = 1'b0;
		ov_check_d  = 1'b0;
		keep_wreg_d = 1'b1;
		case (aluop_i)
			OP_OR, OP_AND, OP_NOR, OP_XOR:
				sel_d = SEL_LOGIC;
			OP_SLL, OP_SRL, OP_SRA:
				sel_d = SEL_SHIFT;
			OP_ADDU, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO:
				sel_d = SEL_ARITH;
			OP_ADD, OP_SUB:
			begin
				// only the trapping forms drop the write on overflow.
				sel_d      = SEL_ARITH;
				ov_check_d = 1'b1;
			end
			OP_MUL:
			begin
				sel_d    = SEL_MUL;
				signed_d = 1'b1;
			end
			OP_MULT, OP_MULTU:
			begin
				// the product goes to HI/LO and never to the register file.
				sel_d       = SEL_MUL;
				signed_d    = (aluop_i == OP_MULT);
				hilo_d      = HILO_PRODUCT;
				keep_wreg_d = 1'b0;
			end
			OP_MFHI, OP_MFLO, OP_MOVZ, OP_MOVN:
				sel_d = SEL_MOVE;
			OP_MTHI:
			begin
				hilo_d      = HILO_SET_HI;
				keep_wreg_d = 1'b0;
			end
			OP_MTLO:
			begin
				hilo_d      = HILO_SET_LO;
				keep_wreg_d = 1'b0;
			end
			default:
				keep_wreg_d = 1'b0;
		endcase
	end

	// control flags, which are low whenever no instruction is held.
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			dec_valid_o <= 1'b0;
			dec_wreg_o  <= 1'b0;
			dec_hilo_o  <= HILO_NONE;
		end
		else
		begin
			dec_valid_o <= op_valid_i;
			dec_wreg_o  <= op_valid_i & wreg_i & keep_wreg_d;
			dec_hilo_o  <= op_valid_i ? hilo_d : HILO_NONE;
		end
	end

	// payload is only loaded on a strobe and otherwise holds.
	always_ff @(posedge clk)
	begin
		if (op_valid_i)
		begin
			dec_op_o       <= aluop_i;
			dec_sel_o      <= sel_d;
			dec_signed_o   <= signed_d;
			dec_ov_check_o <= ov_check_d;
			dec_reg1_o     <= reg1_i;
			dec_reg2_o     <= reg2_i;
			dec_wd_o       <= wd_i;
		end
	end

	// a decoded instruction exists only for one cycle after its strobe.
	a_dec_valid_after_strobe: assert property (@(posedge clk) disable iff (reset_i)
		dec_valid_o |-> $past(op_valid_i));

endmodule

// File: rtl/ex_execute.sv
module ex_execute import ex_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  logic      dec_valid_i,
	input  alu_op_e   dec_op_i,
	input  alu_sel_e  dec_sel_i,
	input  logic      dec_signed_i,
	input  logic      dec_ov_check_i,
	input  hilo_act_e dec_hilo_i,
	input  word_t     dec_reg1_i,
	input  word_t     dec_reg2_i,
	input  reg_addr_t dec_wd_i,
	input  logic      dec_wreg_i,
	output logic      exe_valid_o,
	output alu_op_e   exe_op_o,
	output alu_sel_e  exe_sel_o,
	output word_t     exe_word_o,
	output dword_t    exe_product_o,
	output word_t     exe_reg1_o,
	output hilo_act_e exe_hilo_o,
	output reg_addr_t exe_wd_o,
	output logic      exe_wreg_o
);

	word_t               logic_res;
	word_t               shift_res;
	word_t               arith_res;
	word_t               word_d;
	logic [SHAMT_W-1:0]  shamt;
	logic                is_sub;
	logic                opnd2_sign;
	word_t               opnd2_mux;
	word_t               result_sum;
	logic                ov_sum;
	logic                reg1_lt_reg2;
	word_t               mult_a;
	word_t               mult_b;
	dword_t              mag_product;
	dword_t              product;

	// index of the first set bit seen from the top, WORD_W when none is set.
	function automatic word_t lead_zeros(input word_t w);
		word_t n;
		logic  found;
		n     = word_t'(WORD_W);
		found = 1'b0;
		for (int i = WORD_W - 1; i >= 0; i--)
		begin
			if (!found && w[i])
			begin
				n     = word_t'(WORD_W - 1 - i);
				found = 1'b1;
			end
		end
		return n;
	endfunction

	// ##################################################
	// logic and shift
	// ##################################################

	assign shamt = dec_reg1_i[SHAMT_W-1:0];

	always_comb
	begin
		case (dec_op_i)
			OP_OR:   logic_res = dec_reg1_i | dec_reg2_i;
			OP_AND:  logic_res = dec_reg1_i & dec_reg2_i;
			OP_NOR:  logic_res = ~(dec_reg1_i | dec_reg2_i);
			default: logic_res = dec_reg1_i ^ dec_reg2_i;
		endcase
		case (dec_op_i)
			OP_SLL:  shift_res = dec_reg2_i << shamt;
			OP_SRL:  shift_res = dec_reg2_i >> shamt;
			default: shift_res = word_t'($signed(dec_reg2_i) >>> shamt);
		endcase
	end

	// ##################################################
	// add, subtract, compare, count
	// ##################################################

	// subtraction and signed compare share the adder with a negated operand 2.
	assign is_sub     = (dec_op_i == OP_SUB) || (dec_op_i == OP_SUBU) || (dec_op_i == OP_SLT);
	assign opnd2_mux  = is_sub ? (~dec_reg2_i + 1'b1) : dec_reg2_i;
	assign result_sum = dec_reg1_i + opnd2_mux;

	// overflow is judged on the sign of the true operand 2, so negating the most
	// negative word still counts as overflow.
	assign opnd2_sign = is_sub ? ~dec_reg2_i[WORD_W-1] : dec_reg2_i[WORD_W-1];
	assign ov_sum     = (dec_reg1_i[WORD_W-1] == opnd2_sign) &&
		(result_sum[WORD_W-1] != dec_reg1_i[WORD_W-1]);

	// with different signs the negative one is smaller; otherwise the
	// difference cannot overflow and its sign decides.
	always_comb
	begin
		if (dec_op_i == OP_SLT)
			reg1_lt_reg2 = (dec_reg1_i[WORD_W-1] != dec_reg2_i[WORD_W-1]) ?
				dec_reg1_i[WORD_W-1] : result_sum[WORD_W-1];
		else
			reg1_lt_reg2 = dec_reg1_i < dec_reg2_i;
	end

	always_comb
	begin
		case (dec_op_i)
			OP_SLT, OP_SLTU: arith_res = word_t'(reg1_lt_reg2);
			OP_CLZ:          arith_res = lead_zeros(dec_reg1_i);
			OP_CLO:          arith_res = lead_zeros(~dec_reg1_i);
			default:         arith_res = result_sum;
		endcase
	end

	// ##################################################
	// multiply
	// ##################################################

	// signed forms multiply magnitudes and fix the sign afterwards.
	assign mult_a      = (dec_signed_i && dec_reg1_i[WORD_W-1]) ? (~dec_reg1_i + 1'b1) : dec_reg1_i;
	assign mult_b      = (dec_signed_i && dec_reg2_i[WORD_W-1]) ? (~dec_reg2_i + 1'b1) : dec_reg2_i;
	assign mag_product = {ZERO_WORD, mult_a} * {ZERO_WORD, mult_b};
	assign product     = (dec_signed_i && (dec_reg1_i[WORD_W-1] ^ dec_reg2_i[WORD_W-1])) ?
		(~mag_product + 1'b1) : mag_product;

	// move results are picked later, once HI/LO is at hand.
	always_comb
	begin
		case (dec_sel_i)
			SEL_LOGIC: word_d = logic_res;
			SEL_SHIFT: word_d = shift_res;
			SEL_ARITH: word_d = arith_res;
			SEL_MUL:   word_d = product[WORD_W-1:0];
			default:   word_d = ZERO_WORD;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			exe_valid_o <= 1'b0;
			exe_wreg_o  <= 1'b0;
			exe_hilo_o  <= HILO_NONE;
		end
		else
		begin
			exe_valid_o <= dec_valid_i;
			exe_wreg_o  <= dec_valid_i & dec_wreg_i & ~(dec_ov_check_i & ov_sum);
			exe_hilo_o  <= dec_valid_i ? dec_hilo_i : HILO_NONE;
		end
	end

	always_ff @(posedge clk)
	begin
		if (dec_valid_i)
		begin
			exe_op_o      <= dec_op_i;
			exe_sel_o     <= dec_sel_i;
			exe_word_o    <= word_d;
			exe_product_o <= product;
			exe_reg1_o    <= dec_reg1_i;
			exe_wd_o      <= dec_wd_i;
		end
	end

	// a register write always comes from some result class.
	a_exe_wreg_has_class: assert property (@(posedge clk) disable iff (reset_i)
		exe_valid_o |-> (exe_sel_o != SEL_NONE) || !exe_wreg_o);

endmodule

// File: rtl/ex_pkg.sv
package ex_pkg;

	// ##################################################
	// widths
	// ##################################################

	// one data word of the integer core.
	localparam int WORD_W = 32;

	// register file address width.
	localparam int REG_ADDR_W = 5;

	// only the low bits of operand 1 count as a shift amount.
	localparam int SHAMT_W = 5;

	typedef logic [WORD_W-1:0] word_t;

	// the full product and the HI/LO pair share this type.
	typedef logic [2*WORD_W-1:0] dword_t;

	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// ##################################################
	// encodings
	// ##################################################

	// operation codes that reach the execute stage.
	typedef enum logic [5:0] {
		OP_NOP, OP_OR, OP_AND, OP_NOR, OP_XOR,
		OP_SLL, OP_SRL, OP_SRA,
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
		OP_SLT, OP_SLTU, OP_CLZ, OP_CLO,
		OP_MUL, OP_MULT, OP_MULTU,
		OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
		OP_MOVZ, OP_MOVN
	} alu_op_e;

	// result class, which picks the unit whose word is written back.
	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_LOGIC,
		SEL_SHIFT,
		SEL_ARITH,
		SEL_MUL,
		SEL_MOVE
	} alu_sel_e;

	// what an instruction does to the HI/LO pair.
	// HILO_NONE must stay at zero, since a cleared register means no write.
	typedef enum logic [1:0] {
		HILO_NONE,
		HILO_PRODUCT,
		HILO_SET_HI,
		HILO_SET_LO
	} hilo_act_e;

	// ##################################################
	// helper constants
	// ##################################################

	localparam word_t  ZERO_WORD  = '0;
	localparam dword_t ZERO_DWORD = '0;

endpackage

// File: rtl/ex_result.sv
module ex_result import ex_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  logic      exe_valid_i,
	input  alu_op_e   exe_op_i,
	input  alu_sel_e  exe_sel_i,
	input  word_t     exe_word_i,
	input  dword_t    exe_product_i,
	input  word_t     exe_reg1_i,
	input  hilo_act_e exe_hilo_i,
	input  reg_addr_t exe_wd_i,
	input  logic      exe_wreg_i,
	output logic      res_valid_o,
	output reg_addr_t wd_o,
	output logic      wreg_o,
	output word_t     wdata_o,
	output logic      whilo_o,
	output word_t     hi_o,
	output word_t     lo_o
);

	word_t hi_q;
	word_t lo_q;
	word_t move_res;

	// ##################################################
	// HI/LO pair
	// ##################################################

	// reads and writes of the pair both happen here, so an instruction one
	// cycle behind a writer already sees the new pair without forwarding.
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			{hi_q, lo_q} <= ZERO_DWORD;
		end
		else if (exe_valid_i)
		begin
			case (exe_hilo_i)
				HILO_PRODUCT: {hi_q, lo_q} <= exe_product_i;
				HILO_SET_HI:  hi_q <= exe_reg1_i;
				HILO_SET_LO:  lo_q <= exe_reg1_i;
				default:      {hi_q, lo_q} <= {hi_q, lo_q};
			endcase
		end
	end

	assign hi_o = hi_q;
	assign lo_o = lo_q;

	// ##################################################
	// write-back
	// ##################################################

	// movz and movn pass operand 1 whatever the condition operand holds.
	always_comb
	begin
		case (exe_op_i)
			OP_MFHI:          move_res = hi_q;
			OP_MFLO:          move_res = lo_q;
			OP_MOVZ, OP_MOVN: move_res = exe_reg1_i;
			default:          move_res = ZERO_WORD;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			res_valid_o <= 1'b0;
			wreg_o      <= 1'b0;
			whilo_o     <= 1'b0;
		end
		else
		begin
			res_valid_o <= exe_valid_i;
			wreg_o      <= exe_valid_i & exe_wreg_i;
			whilo_o     <= exe_valid_i & (exe_hilo_i != HILO_NONE);
		end
	end

	always_ff @(posedge clk)
	begin
		if (exe_valid_i)
		begin
			wd_o    <= exe_wd_i;
			wdata_o <= (exe_sel_i == SEL_MOVE) ? move_res : exe_word_i;
		end
	end

	// write requests are only ever seen together with a valid result.
	a_res_flags_need_valid: assert property (@(posedge clk) disable iff (reset_i)
		(whilo_o || wreg_o) |-> res_valid_o);

endmodule

// File: rtl/ex_unit.sv
module ex_unit import ex_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  logic      op_valid_i,
	input  alu_op_e   aluop_i,
	input  word_t     reg1_i,
	input  word_t     reg2_i,
	input  reg_addr_t wd_i,
	input  logic      wreg_i,
	output logic      res_valid_o,
	output reg_addr_t wd_o,
	output logic      wreg_o,
	output word_t     wdata_o,
	output logic      whilo_o,
	output word_t     hi_o,
	output word_t     lo_o
);

	// decode to execute.
	logic      dec_valid, dec_signed, dec_ov_check, dec_wreg;
	alu_op_e   dec_op;
	alu_sel_e  dec_sel;
	hilo_act_e dec_hilo;
	word_t     dec_reg1, dec_reg2;
	reg_addr_t dec_wd;

	// execute to result.
	logic      exe_valid, exe_wreg;
	alu_op_e   exe_op;
	alu_sel_e  exe_sel;
	hilo_act_e exe_hilo;
	word_t     exe_word, exe_reg1;
	dword_t    exe_product;
	reg_addr_t exe_wd;

	ex_decode i_ex_decode (.clk, .reset_i, .op_valid_i, .aluop_i, .reg1_i, .reg2_i,
		.wd_i, .wreg_i, .dec_valid_o(dec_valid), .dec_op_o(dec_op), .dec_sel_o(dec_sel),
		.dec_signed_o(dec_signed), .dec_ov_check_o(dec_ov_check), .dec_hilo_o(dec_hilo),
		.dec_reg1_o(dec_reg1), .dec_reg2_o(dec_reg2), .dec_wd_o(dec_wd),
		.dec_wreg_o(dec_wreg));

	ex_execute i_ex_execute (.clk, .reset_i, .dec_valid_i(dec_valid), .dec_op_i(dec_op),
		.dec_sel_i(dec_sel), .dec_signed_i(dec_signed), .dec_ov_check_i(dec_ov_check),
		.dec_hilo_i(dec_hilo), .dec_reg1_i(dec_reg1), .dec_reg2_i(dec_reg2),
		.dec_wd_i(dec_wd), .dec_wreg_i(dec_wreg), .exe_valid_o(exe_valid),
		.exe_op_o(exe_op), .exe_sel_o(exe_sel), .exe_word_o(exe_word),
		.exe_product_o(exe_product), .exe_reg1_o(exe_reg1), .exe_hilo_o(exe_hilo),
		.exe_wd_o(exe_wd), .exe_wreg_o(exe_wreg));

	// HI/LO lives in the last step, two cycles behind the strobe.
	ex_result i_ex_result (.clk, .reset_i, .exe_valid_i(exe_valid), .exe_op_i(exe_op),
		.exe_sel_i(exe_sel), .exe_word_i(exe_word), .exe_product_i(exe_product),
		.exe_reg1_i(exe_reg1), .exe_hilo_i(exe_hilo), .exe_wd_i(exe_wd),
		.exe_wreg_i(exe_wreg), .res_valid_o, .wd_o, .wreg_o, .wdata_o, .whilo_o,
		.hi_o, .lo_o);

endmodule

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run from its log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_unit -f list.f \
	-o tb_ex_unit > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_ex_unit > sim.log 2>&1
grep -q "Test failed" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "Test passed" sim.log || { echo "simulation gave no result, see sim.log"; exit 1; }
echo "simulation passed"

// File: include/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// leading zeros of a word, WORD_W for an all-zero word.
function automatic word_t ref_clz(input word_t w);
	int n;
	n = 0;
	while (n < WORD_W && !w[WORD_W-1-n])
		n++;
	return word_t'(n);
endfunction

// full product, taken from wide signed arithmetic for the signed forms.
function automatic dword_t ref_product(input alu_op_e op, input word_t a, input word_t b);
	if (op == OP_MULTU)
		return {ZERO_WORD, a} * {ZERO_WORD, b};
	return dword_t'(longint'($signed(a)) * longint'($signed(b)));
endfunction

// expected wdata_o, reading the pair as it stands before this instruction.
function automatic word_t ref_word(input alu_op_e op, input word_t a, input word_t b,
	input dword_t hilo);
	dword_t p;
	p = ref_product(op, a, b);
	case (op)
		OP_OR:                    return a | b;
		OP_AND:                   return a & b;
		OP_NOR:                   return ~(a | b);
		OP_XOR:                   return a ^ b;
		OP_SLL:                   return b << a[SHAMT_W-1:0];
		OP_SRL:                   return b >> a[SHAMT_W-1:0];
		OP_SRA:                   return word_t'($signed(b) >>> a[SHAMT_W-1:0]);
		OP_ADD, OP_ADDU:          return a + b;
		OP_SUB, OP_SUBU:          return a - b;
		OP_SLT:                   return word_t'($signed(a) < $signed(b));
		OP_SLTU:                  return word_t'(a < b);
		OP_CLZ:                   return ref_clz(a);
		OP_CLO:                   return ref_clz(~a);
		OP_MUL, OP_MULT, OP_MULTU: return p[WORD_W-1:0];
		OP_MFHI:                  return hilo[2*WORD_W-1:WORD_W];
		OP_MFLO:                  return hilo[WORD_W-1:0];
		OP_MOVZ, OP_MOVN:         return a;
		default:                  return ZERO_WORD;
	endcase
endfunction

// expected wreg_o; add and sub lose the write when the true result leaves 32 bits.
function automatic logic ref_wreg(input alu_op_e op, input word_t a, input word_t b,
	input logic wreg);
	longint s;
	s = (op == OP_SUB) ? longint'($signed(a)) - longint'($signed(b)) :
		longint'($signed(a)) + longint'($signed(b));
	case (op)
		OP_NOP, OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO: return 1'b0;
		OP_ADD, OP_SUB: return wreg && (s <= 64'sd2147483647) && (s >= -64'sd2147483648);
		default:        return wreg;
	endcase
endfunction

// pair after this instruction; an unchanged pair means no HI/LO write.
function automatic dword_t ref_hilo(input alu_op_e op, input word_t a, input word_t b,
	input dword_t hilo);
	case (op)
		OP_MULT, OP_MULTU: return ref_product(op, a, b);
		OP_MTHI:           return {a, hilo[WORD_W-1:0]};
		OP_MTLO:           return {hilo[2*WORD_W-1:WORD_W], a};
		default:           return hilo;
	endcase
endfunction

// expected whilo_o for one instruction.
function automatic logic ref_whilo(input alu_op_e op);
	return (op == OP_MULT) || (op == OP_MULTU) || (op == OP_MTHI) || (op == OP_MTLO);
endfunction

`endif

// File: test/tb_ex_unit.sv
module tb_ex_unit import ex_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	// run length and the watchdog limit. 400 instructions with about one idle
	// cycle in eight, plus reset and latency, fit well inside the limit.
	localparam int N_DIRECTED = 15;
	localparam int N_RANDOM   = 400 - N_DIRECTED;
	localparam int MAX_CYCLES = 1000;

	// one expected result, with the cycle count at which it must be visible.
	typedef struct packed {
		int        due;
		word_t     wdata;
		reg_addr_t wd;
		logic      wreg;
		logic      whilo;
		dword_t    hilo;
	} exp_t;

	logic      clk;
	logic      reset_i;
	logic      op_valid_i;
	alu_op_e   aluop_i;
	word_t     reg1_i;
	word_t     reg2_i;
	reg_addr_t wd_i;
	logic      wreg_i;
	logic      res_valid_o;
	reg_addr_t wd_o;
	logic      wreg_o;
	word_t     wdata_o;
	logic      whilo_o;
	word_t     hi_o;
	word_t     lo_o;

	exp_t        exp_q[$];
	exp_t        head;
	logic        exp_due = 1'b0;
	dword_t      model_hilo = '0;
	logic [31:0] lfsr_state = 32'he6b9_1d97;
	int          cycle_q = 0;
	int          sent_count = 0;
	int          pulse_count = 0;

	alu_op_e kept_ops [24] = '{OP_OR, OP_AND, OP_NOR, OP_XOR, OP_SLL, OP_SRL, OP_SRA,
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO, OP_MUL,
		OP_MULT, OP_MULTU, OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO, OP_MOVZ, OP_MOVN};

	`include "ex_ref_model.svh"

	ex_unit i_ex_unit (.clk, .reset_i, .op_valid_i, .aluop_i, .reg1_i, .reg2_i, .wd_i,
		.wreg_i, .res_valid_o, .wd_o, .wreg_o, .wdata_o, .whilo_o, .hi_o, .lo_o);

	// ##################################################
	// reporting
	// ##################################################

	task automatic report_mismatch(input string name, input logic [63:0] expv,
		input logic [63:0] actv);
		$display("[ERROR] %0d ns: %s expected 0x%0h, actual 0x%0h", $time, name, expv, actv);
		$display("Test failed");
		$fatal(1, "value mismatch on %s", name);
	endtask

	task automatic report_failure(input string what);
		$display("%0d ns: %s", $time, what);
		$display("Test failed");
		$fatal(1, "%s", what);
	endtask

	// ##################################################
	// random numbers
	// ##################################################

	// taps 32, 22, 2 and 1 give a maximal length sequence.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one LFSR step per bit, the new bit entering at the bottom.
	function automatic word_t take_bits(input int n);
		word_t r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[WORD_W-2:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// half the operands are plain random; the rest are small numbers, which
	// double as shift amounts, or the words at the edges of the signed range.
	function automatic word_t pick_operand();
		word_t w;
		logic [1:0] mode;
		logic [1:0] edge_sel;
		w        = take_bits(WORD_W);
		mode     = 2'(take_bits(2));
		edge_sel = 2'(take_bits(2));
		if (mode == 2'd1)
			w = word_t'(take_bits(SHAMT_W));
		else if (mode == 2'd2)
		begin
			case (edge_sel)
				2'd0:    w = 32'h8000_0000;
				2'd1:    w = 32'h7fff_ffff;
				2'd2:    w = 32'hffff_ffff;
				default: w = 32'h0000_0000;
			endcase
		end
		return w;
	endfunction

	// ##################################################
	// clock, cycle count and watchdog
	// ##################################################

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_q <= cycle_q + 1;
		if (cycle_q >= MAX_CYCLES)
			report_failure("timeout: the run did not finish within the cycle limit");
	end

	// ##################################################
	// stimulus
	// ##################################################

	// drive one strobe and queue what the model says must come out of it.
	// a set force_wreg keeps the write request high whatever the LFSR gives.
	task automatic issue(input alu_op_e op, input word_t a, input word_t b,
		input logic force_wreg = 1'b0);
		exp_t e;
		@(posedge clk);
		#5;
		op_valid_i = 1'b1;
		aluop_i    = op;
		reg1_i     = a;
		reg2_i     = b;
		wd_i       = reg_addr_t'(take_bits(REG_ADDR_W));
		wreg_i     = (take_bits(2) != 0) || force_wreg;
		// sampled at the next edge, seen after the third edge from here.
		e.due      = cycle_q + 3;
		e.wd       = wd_i;
		e.wdata    = ref_word(op, a, b, model_hilo);
		e.wreg     = ref_wreg(op, a, b, wreg_i);
		e.whilo    = ref_whilo(op);
		model_hilo = ref_hilo(op, a, b, model_hilo);
		e.hilo     = model_hilo;
		exp_q.push_back(e);
		sent_count++;
	endtask

	task automatic idle();
		@(posedge clk);
		#5;
		op_valid_i = 1'b0;
	endtask

	initial
	begin
		reset_i    = 1'b1;
		op_valid_i = 1'b0;
		aluop_i    = OP_NOP;
		reg1_i     = '0;
		reg2_i     = '0;
		wd_i       = '0;
		wreg_i     = 1'b0;
		repeat (8) @(posedge clk);
		#5;
		reset_i = 1'b0;

		// corner cases first, the HI/LO reads right behind their writers.
		issue(OP_MULT, 32'hffff_fff3, 32'h0001_2345);
		issue(OP_MFHI, '0, '0);
		issue(OP_MFLO, '0, '0);
		issue(OP_MULTU, 32'hffff_ffff, 32'hffff_ffff);
		issue(OP_MFLO, '0, '0);
		issue(OP_MTHI, 32'h1234_5678, '0);
		issue(OP_MFLO, '0, '0);
		issue(OP_MTLO, 32'h9abc_def0, '0);
		issue(OP_MFHI, '0, '0);
		// the overflow corners request a write, so a dropped or kept write shows.
		issue(OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 1'b1);
		issue(OP_SUB, 32'h8000_0000, 32'h0000_0001, 1'b1);
		issue(OP_ADDU, 32'h7fff_ffff, 32'h0000_0001, 1'b1);
		issue(OP_CLZ, 32'h0000_0000, '0);
		issue(OP_CLO, 32'hffff_ffff, '0);
		issue(OP_SRA, 32'd31, 32'h8000_0000);

		// random traffic with an idle cycle now and then.
		for (int i = 0; i < N_RANDOM; i++)
		begin
			while (take_bits(3) == 0)
				idle();
			issue(kept_ops[take_bits(5) % 24], pick_operand(), pick_operand());
		end
		idle();

		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		if (pulse_count == sent_count)
		begin
			$display("Test passed");
			$finish;
		end
		else
			report_failure("the number of result pulses differs from the number of strobes");
	end

	// ##################################################
	// checking
	// ##################################################

	// the queue head is moved to flat signals half a cycle before the edge
	// at which the assertions sample it.
	always @(negedge clk)
	begin
		if (res_valid_o)
			pulse_count++;
		if (exp_q.size() > 0 && exp_q[0].due == cycle_q)
		begin
			head    = exp_q.pop_front();
			exp_due = 1'b1;
		end
		else
			exp_due = 1'b0;
	end

	a_pulse_present: assert property (@(posedge clk) disable iff (reset_i)
		exp_due |-> res_valid_o)
		else report_failure("an expected result pulse is missing");

	a_pulse_absent: assert property (@(posedge clk) disable iff (reset_i)
		!exp_due |-> !res_valid_o && !wreg_o && !whilo_o)
		else report_failure("a result pulse or write request came without a strobe");

	a_wdata: assert property (@(posedge clk) disable iff (reset_i)
		exp_due |-> wdata_o == head.wdata)
		else report_mismatch("wdata_o", 64'($sampled(head.wdata)), 64'($sampled(wdata_o)));

	a_wd: assert property (@(posedge clk) disable iff (reset_i)
		exp_due |-> wd_o == head.wd)
		else report_mismatch("wd_o", 64'($sampled(head.wd)), 64'($sampled(wd_o)));

	a_wreg: assert property (@(posedge clk) disable iff (reset_i)
		exp_due |-> wreg_o == head.wreg)
		else report_mismatch("wreg_o", 64'($sampled(head.wreg)), 64'($sampled(wreg_o)));

	a_whilo: assert property (@(posedge clk) disable iff (reset_i)
		exp_due |-> whilo_o == head.whilo)
		else report_mismatch("whilo_o", 64'($sampled(head.whilo)), 64'($sampled(whilo_o)));

	a_hi: assert property (@(posedge clk) disable iff (reset_i)
		exp_due |-> hi_o == head.hilo[2*WORD_W-1:WORD_W])
		else report_mismatch("hi_o", 64'($sampled(head.hilo[2*WORD_W-1:WORD_W])),
			64'($sampled(hi_o)));

	a_lo: assert property (@(posedge clk) disable iff (reset_i)
		exp_due |-> lo_o == head.hilo[WORD_W-1:0])
		else report_mismatch("lo_o", 64'($sampled(head.hilo[WORD_W-1:0])),
			64'($sampled(lo_o)));

endmodule
